/* Bender.yml */
package:
  name: tcp_rx

sources:
  - files:
      - verilog/tcp_rx_pkg.sv
      - verilog/stream_fifo.sv
      - verilog/tcp_hdr_decoder.sv
      - verilog/tcp_port_filter.sv
      - verilog/tcp_rx_result.sv
      - verilog/tcp_rx_top.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_tcp_rx.sv

/* files.f */
+incdir+tb
verilog/tcp_rx_pkg.sv
verilog/stream_fifo.sv
verilog/tcp_hdr_decoder.sv
verilog/tcp_port_filter.sv
verilog/tcp_rx_result.sv
verilog/tcp_rx_top.sv
tb/tb_tcp_rx.sv

/* tb/tb_tcp_rx_vectors.svh */
`ifndef TB_TCP_RX_VECTORS_SVH
`define TB_TCP_RX_VECTORS_SVH

// the columns are src port, dst port, seq, ack, flags, window, data offset,
// payload length, truncation length (0 is none) and expected accept.
typedef struct packed {
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [31:0] seq_num;
    logic [31:0] ack_num;
    logic [7:0]  flags;
    logic [15:0] window;
    logic [3:0]  data_offs;
    logic [7:0]  pay_len;
    logic [7:0]  trunc;
    logic        accept;
} seg_vec_t;

localparam logic [15:0] LISTEN_PORT = 16'h1f90;
localparam int          NUM_SEGS    = 13;

localparam seg_vec_t SEG_VECS [NUM_SEGS] = '{
    '{16'hc001, 16'h1f90, 32'h00001000, 32'h00000000, 8'h02, 16'hffff, 4'd5, 8'd12, 8'd0, 1'b1},
    '{16'hc002, 16'h1f90, 32'h8000fff0, 32'h12345678, 8'h18, 16'h7210, 4'd8, 8'd7, 8'd0, 1'b1},
    '{16'hc003, 16'h0050, 32'h00000001, 32'h00000002, 8'h10, 16'h0400, 4'd5, 8'd9, 8'd0, 1'b0},
    '{16'hc004, 16'h1f90, 32'hdeadbeef, 32'hcafef00d, 8'h11, 16'h0001, 4'd6, 8'd3, 8'd0, 1'b1},
    '{16'h0016, 16'h1f90, 32'h00000400, 32'h00000800, 8'h10, 16'h2000, 4'd5, 8'd0, 8'd0, 1'b1},
    '{16'hc005, 16'h1f90, 32'h11111111, 32'h22222222, 8'h18, 16'h1000, 4'd5, 8'd5, 8'd11, 1'b0},
    '{16'hc006, 16'h1f90, 32'h33333333, 32'h44444444, 8'h18, 16'h1000, 4'd7, 8'd4, 8'd22, 1'b0},
    '{16'hfffe, 16'h1f90, 32'hffffffff, 32'h00000000, 8'hff, 16'hfffe, 4'd15, 8'd40, 8'd0, 1'b1},
    '{16'hc008, 16'h1f91, 32'h55555555, 32'h66666666, 8'h18, 16'h0800, 4'd10, 8'd4, 8'd0, 1'b0},
    '{16'hc009, 16'h1f90, 32'h00000009, 32'h0000000a, 8'h14, 16'h0000, 4'd9, 8'd0, 8'd0, 1'b1},
    '{16'hc00b, 16'h1f90, 32'h0000000d, 32'h0000000e, 8'h18, 16'h0200, 4'd5, 8'd1, 8'd0, 1'b1},
    '{16'hc00c, 16'h1f90, 32'h0000000f, 32'h00000010, 8'h18, 16'h0300, 4'd5, 8'd6, 8'd1, 1'b0},
    '{16'hc00d, 16'h1f90, 32'h00000011, 32'h00000012, 8'h18, 16'h0400, 4'd5, 8'd25, 8'd0, 1'b1}
};

`endif

/* tb/tb_tcp_rx.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_tcp_rx;
    import tcp_rx_pkg::*;

    `include "tb_tcp_rx_vectors.svh"

    logic        i_clk = 1'b0;
    logic        i_rst;
    logic [15:0] i_listen_port;
    logic [7:0]  i_s_data;
    logic        i_s_last;
    logic        i_s_valid;
    logic        o_s_ready;
    tcp_hdr_t    o_hdr_data;
    logic        o_hdr_valid;
    logic        i_hdr_ready;
    logic [7:0]  o_m_data;
    logic        o_m_last;
    logic        o_m_valid;
    logic        i_m_ready;

    integer      seed    = 32'h8224;
    integer      bp_seed = 32'h8224;
    logic [31:0] bp_bits;
    tcp_hdr_t    exp_hdr_q [$];
    int          hdr_test_q [$];
    logic [8:0]  exp_pay_q [$];     // last in bit 8.
    int          pay_test_q [$];
    int          test_errs [NUM_SEGS] = '{default: 0};
    int          error_count    = 0;
    int          tests_failed   = 0;
    int          hdr_seen       = 0;
    int          hdr_expected   = 0;
    int          bytes_seen     = 0;
    int          bytes_expected = 0;

    tcp_rx_top uut (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_listen_port (i_listen_port),
        .i_s_data      (i_s_data),
        .i_s_last      (i_s_last),
        .i_s_valid     (i_s_valid),
        .o_s_ready     (o_s_ready),
        .o_hdr_data    (o_hdr_data),
        .o_hdr_valid   (o_hdr_valid),
        .i_hdr_ready   (i_hdr_ready),
        .o_m_data      (o_m_data),
        .o_m_last      (o_m_last),
        .o_m_valid     (o_m_valid),
        .i_m_ready     (i_m_ready)
    );

    always #2 i_clk = ~i_clk;

    // bytes put on the wire for one table entry.
    function automatic int seg_length(input int t);
        if (SEG_VECS[t].trunc != 0) begin
            return int'(SEG_VECS[t].trunc);
        end
        return 4 * int'(SEG_VECS[t].data_offs) + int'(SEG_VECS[t].pay_len);
    endfunction

    task automatic finish_test(input int t);
        string kind;
        kind = (SEG_VECS[t].trunc != 0) ? "truncated" :
               (SEG_VECS[t].accept ? "accepted" : "dropped");
        if (test_errs[t] == 0) begin
            $display("test %2d (%s): ok", t, kind);
        end else begin
            tests_failed++;
            $display("test %2d (%s): failed with %0d errors", t, kind, test_errs[t]);
        end
    endtask

    // called on a falling edge, returns on the falling edge after the transfer.
    task automatic drive_byte(input logic [7:0] data, input logic last);
        i_s_data  = data;
        i_s_last  = last;
        i_s_valid = 1'b1;
        @(posedge i_clk);
        while (!o_s_ready) begin
            @(posedge i_clk);
        end
        @(negedge i_clk);
        i_s_valid = 1'b0;
        i_s_last  = 1'b0;
    endtask

    task automatic send_segment(input int t);
        seg_vec_t     v;
        logic [159:0] fixed;
        logic [7:0]   seg_bytes [$];
        tcp_hdr_t     exp_hdr;
        logic [31:0]  r;
        v = SEG_VECS[t];
        r = $random(seed);
        // checksum and urgent pointer are random, the parser ignores them.
        fixed = {v.src_port, v.dst_port, v.seq_num, v.ack_num,
                 v.data_offs, 4'h0, v.flags, v.window, r};
        for (int i = 0; i < 4 * int'(v.data_offs); i++) begin
            r = $random(seed);
            if (i < TCP_MIN_HDR_BYTES) begin
                seg_bytes.push_back(fixed[159 - 8 * i -: 8]);
            end else begin
                seg_bytes.push_back(r[7:0]);   // option byte.
            end
        end
        for (int i = 0; i < int'(v.pay_len); i++) begin
            r = $random(seed);
            seg_bytes.push_back(r[7:0]);
            if (v.accept) begin
                exp_pay_q.push_back({i == int'(v.pay_len) - 1, r[7:0]});
                pay_test_q.push_back(t);
            end
        end
        if (v.accept) begin
            exp_hdr.src_port  = v.src_port;
            exp_hdr.dst_port  = v.dst_port;
            exp_hdr.seq_num   = v.seq_num;
            exp_hdr.ack_num   = v.ack_num;
            exp_hdr.data_offs = v.data_offs;
            exp_hdr.flags     = v.flags;
            exp_hdr.window    = v.window;
            exp_hdr_q.push_back(exp_hdr);
            hdr_test_q.push_back(t);
            hdr_expected++;
            bytes_expected += int'(v.pay_len);
        end
        for (int i = 0; i < seg_length(t); i++) begin
            r = $random(seed);
            if (r[1:0] == 2'b00) begin
                repeat (1 + r[3:2]) @(negedge i_clk);   // idle gap.
            end
            drive_byte(seg_bytes[i], i == seg_length(t) - 1);
        end
        if (!v.accept) begin
            finish_test(t);
        end
    endtask

    task automatic check_header();
        tcp_hdr_t exp_hdr;
        int       t;
        hdr_seen++;
        if (exp_hdr_q.size() == 0) begin
            error_count++;
            $display("unexpected header record for port 0x%04h", o_hdr_data.dst_port);
        end else begin
            exp_hdr = exp_hdr_q.pop_front();
            t = hdr_test_q.pop_front();
            if (o_hdr_data !== exp_hdr) begin
                error_count++;
                test_errs[t]++;
                $display("Error: o_hdr_data = 0x%h, expected 0x%h (test %0d)",
                         o_hdr_data, exp_hdr, t);
            end
            if (SEG_VECS[t].pay_len == 0) begin
                finish_test(t);
            end
        end
    endtask

    task automatic check_payload();
        logic [8:0] exp_item;
        int         t;
        bytes_seen++;
        if (exp_pay_q.size() == 0) begin
            error_count++;
            $display("unexpected payload byte 0x%02h", o_m_data);
        end else begin
            exp_item = exp_pay_q.pop_front();
            t = pay_test_q.pop_front();
            if (o_m_data !== exp_item[7:0]) begin
                error_count++;
                test_errs[t]++;
                $display("Error: o_m_data = 0x%02h, expected 0x%02h (test %0d)",
                         o_m_data, exp_item[7:0], t);
            end
            if (o_m_last !== exp_item[8]) begin
                error_count++;
                test_errs[t]++;
                $display("Error: o_m_last = 0x%0h, expected 0x%0h (test %0d)",
                         o_m_last, exp_item[8], t);
            end
            if (exp_item[8]) begin
                finish_test(t);
            end
        end
    endtask

    // readies change on the falling edge, transfers are taken on the rising edge.
    always @(negedge i_clk) begin
        bp_bits     = $random(bp_seed);
        i_hdr_ready = bp_bits[4];
        i_m_ready   = (bp_bits[9:8] == 2'b11);   // slow reader, so the payload fifo fills.
    end

    always @(posedge i_clk) begin
        if (!i_rst && o_hdr_valid && i_hdr_ready) begin
            check_header();
        end
        if (!i_rst && o_m_valid && i_m_ready) begin
            check_payload();
        end
    end

    initial begin
        i_rst         = 1'b1;
        i_listen_port = LISTEN_PORT;
        i_s_data      = 8'h00;
        i_s_last      = 1'b0;
        i_s_valid     = 1'b0;
        i_hdr_ready   = 1'b0;
        i_m_ready     = 1'b0;
        repeat (16) @(posedge i_clk);
        @(negedge i_clk);
        i_rst = 1'b0;
        if (!o_s_ready || o_hdr_valid || o_m_valid) begin
            error_count++;
            $display("outputs are not idle after reset");
        end
        for (int t = 0; t < NUM_SEGS; t++) begin
            send_segment(t);
        end
        while (exp_hdr_q.size() != 0 || exp_pay_q.size() != 0) begin
            @(negedge i_clk);
        end
        repeat (64) @(negedge i_clk);   // room for anything extra to come out.
        if (hdr_seen != hdr_expected) begin
            error_count++;
            $display("Error: o_hdr_valid transfers = 0x%0h, expected 0x%0h",
                     hdr_seen, hdr_expected);
        end
        if (bytes_seen != bytes_expected) begin
            error_count++;
            $display("Error: o_m_valid transfers = 0x%0h, expected 0x%0h",
                     bytes_seen, bytes_expected);
        end
        $display("tests %0d, failed %0d, errors %0d, records %0d, payload bytes %0d",
                 NUM_SEGS, tests_failed, error_count, hdr_seen, bytes_seen);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        int limit;
        limit = 1000;
        for (int t = 0; t < NUM_SEGS; t++) begin
            limit += 20 * seg_length(t);
        end
        repeat (limit) @(posedge i_clk);
        $display("timeout after %0d cycles, %0d header records and %0d payload bytes missing",
                 limit, exp_hdr_q.size(), exp_pay_q.size());
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/stream_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module stream_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  wire  i_clk,
    input  wire  i_rst,

    input  T     i_data,
    input  wire  i_valid,
    output logic o_ready,

    output T     o_data,
    output logic o_valid,
    input  wire  i_ready
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T               mem [DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic [CW-1:0]  count;
    logic           wr_en;
    logic           rd_en;

    assign o_ready = (count != CW'(DEPTH));
    assign o_valid = (count != '0);
    assign o_data  = mem[rd_ptr];

    assign wr_en = i_valid && o_ready;
    assign rd_en = o_valid && i_ready;

    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (!wr_en && rd_en) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/tcp_hdr_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module tcp_hdr_decoder (
    input  wire                  i_clk,
    input  wire                  i_rst,

    input  wire [7:0]            i_s_data,
    input  wire                  i_s_last,
    input  wire                  i_s_valid,
    output logic                 o_s_ready,

    output tcp_rx_pkg::tcp_hdr_t o_hdr_data,
    output logic                 o_hdr_valid,
    input  wire                  i_hdr_ready,

    output logic [7:0]           o_pay_data,
    output logic                 o_pay_last,
    output logic                 o_pay_valid,
    input  wire                  i_pay_ready
);
    import tcp_rx_pkg::*;

    typedef enum logic {ST_HEADER, ST_PAYLOAD} state_t;

    state_t                state;
    logic [BYTE_CNT_W-1:0] byte_cnt;
    logic [BYTE_CNT_W-1:0] last_idx;
    tcp_hdr_t              hdr_q;
    logic                  hdr_valid_q;
    logic                  hdr_acc;
    logic                  hdr_done;

    // index of the final header byte, options included.
    assign last_idx = {hdr_q.data_offs, 2'b00} - 1'b1;
    assign hdr_done = (byte_cnt >= BYTE_CNT_W'(TCP_MIN_HDR_BYTES - 1)) &&
                      (byte_cnt >= last_idx);

    // no new bytes while a finished record waits.
    assign o_s_ready = !hdr_valid_q && ((state == ST_HEADER) || i_pay_ready);
    assign hdr_acc   = (state == ST_HEADER) && i_s_valid && o_s_ready;

    assign o_pay_data  = i_s_data;
    assign o_pay_last  = i_s_last;
    assign o_pay_valid = (state == ST_PAYLOAD) && i_s_valid && !hdr_valid_q;

    assign o_hdr_data  = hdr_q;
    assign o_hdr_valid = hdr_valid_q;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state       <= ST_HEADER;
            byte_cnt    <= '0;
            hdr_valid_q <= 1'b0;
        end else begin
            if (hdr_valid_q && i_hdr_ready) begin
                hdr_valid_q <= 1'b0;
            end

            case (state)
                ST_HEADER: begin
                    if (hdr_acc) begin
                        if (hdr_done) begin
                            hdr_valid_q <= 1'b1;
                            byte_cnt    <= '0;
                            if (!i_s_last) begin
                                state <= ST_PAYLOAD;   // else a segment without payload.
                            end
                        end else if (i_s_last) begin
                            byte_cnt <= '0;            // truncated, nothing is sent.
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end
                ST_PAYLOAD: begin
                    if (i_s_valid && o_s_ready && i_s_last) begin
                        state <= ST_HEADER;
                    end
                end
                default: state <= ST_HEADER;
            endcase
        end
    end

    // fields are shifted in msb first; checksum, urgent pointer and options fall through.
    always_ff @(posedge i_clk) begin
        if (hdr_acc) begin
            case (byte_cnt) inside
                [OFFS_SRC_PORT:OFFS_DST_PORT-1]:
                    hdr_q.src_port <= {hdr_q.src_port[7:0], i_s_data};
                [OFFS_DST_PORT:OFFS_SEQ-1]:
                    hdr_q.dst_port <= {hdr_q.dst_port[7:0], i_s_data};
                [OFFS_SEQ:OFFS_ACK-1]:
                    hdr_q.seq_num <= {hdr_q.seq_num[23:0], i_s_data};
                [OFFS_ACK:OFFS_DATA_OFFS-1]:
                    hdr_q.ack_num <= {hdr_q.ack_num[23:0], i_s_data};
                OFFS_DATA_OFFS:
                    hdr_q.data_offs <= i_s_data[7:4];
                OFFS_FLAGS:
                    hdr_q.flags <= i_s_data;
                [OFFS_WINDOW:OFFS_WINDOW+1]:
                    hdr_q.window <= {hdr_q.window[7:0], i_s_data};
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/tcp_port_filter.sv */
`timescale 1ns/10ps
`default_nettype none

module tcp_port_filter (
    input  wire                  i_clk,
    input  wire                  i_rst,
    input  wire [15:0]           i_listen_port,

    input  tcp_rx_pkg::tcp_hdr_t i_hdr_data,
    input  wire                  i_hdr_valid,
    output logic                 o_hdr_ready,

    input  wire [7:0]            i_pay_data,
    input  wire                  i_pay_last,
    input  wire                  i_pay_valid,
    output logic                 o_pay_ready,

    output tcp_rx_pkg::tcp_hdr_t o_hdr_data,
    output logic                 o_hdr_valid,
    input  wire                  i_hdr_ready,

    output logic [7:0]           o_pay_data,
    output logic                 o_pay_last,
    output logic                 o_pay_valid,
    input  wire                  i_pay_ready
);

    logic match;
    logic keep_q;

    assign match = (i_hdr_data.dst_port == i_listen_port);

    // a dropped header is swallowed here.
    assign o_hdr_data  = i_hdr_data;
    assign o_hdr_valid = i_hdr_valid && match;
    assign o_hdr_ready = match ? i_hdr_ready : 1'b1;

    assign o_pay_data  = i_pay_data;
    assign o_pay_last  = i_pay_last;
    assign o_pay_valid = i_pay_valid && keep_q;
    assign o_pay_ready = keep_q ? i_pay_ready : 1'b1;   // drain dropped payload.

    // decision holds until the next header, payload never precedes its header.
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            keep_q <= 1'b0;
        end else if (i_hdr_valid && o_hdr_ready) begin
            keep_q <= match;
        end
    end

endmodule

`default_nettype wire

/* verilog/tcp_rx_pkg.sv */
`default_nettype none

package tcp_rx_pkg;

    localparam int TCP_MIN_HDR_BYTES = 20;

    // first byte of each field, counted from the start of the tcp header.
    localparam int OFFS_SRC_PORT  = 0;
    localparam int OFFS_DST_PORT  = 2;
    localparam int OFFS_SEQ       = 4;
    localparam int OFFS_ACK       = 8;
    localparam int OFFS_DATA_OFFS = 12;
    localparam int OFFS_FLAGS     = 13;
    localparam int OFFS_WINDOW    = 14;

    localparam int BYTE_CNT_W = 6;     // up to 60 header bytes.

    localparam int HDR_FIFO_DEPTH = 4;
    localparam int PAY_FIFO_DEPTH = 16;

    typedef struct packed {
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [31:0] seq_num;
        logic [31:0] ack_num;
        logic [3:0]  data_offs;   // in 32-bit words.
        logic [7:0]  flags;
        logic [15:0] window;
    } tcp_hdr_t;

endpackage

`default_nettype wire

/* verilog/tcp_rx_result.sv */
`timescale 1ns/10ps
`default_nettype none

module tcp_rx_result (
    input  wire                  i_clk,
    input  wire                  i_rst,

    input  tcp_rx_pkg::tcp_hdr_t i_hdr_data,
    input  wire                  i_hdr_valid,
    output logic                 o_hdr_ready,

    input  wire [7:0]            i_pay_data,
    input  wire                  i_pay_last,
    input  wire                  i_pay_valid,
    output logic                 o_pay_ready,

    output tcp_rx_pkg::tcp_hdr_t o_hdr_data,
    output logic                 o_hdr_valid,
    input  wire                  i_hdr_ready,

    output logic [7:0]           o_m_data,
    output logic                 o_m_last,
    output logic                 o_m_valid,
    input  wire                  i_m_ready
);
    import tcp_rx_pkg::*;

    logic [8:0] pay_in;
    logic [8:0] pay_out;

    assign pay_in = {i_pay_last, i_pay_data};   // last rides in bit 8.

    stream_fifo #(
        .T     (tcp_hdr_t),
        .DEPTH (HDR_FIFO_DEPTH)
    ) u_hdr_fifo (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_data  (i_hdr_data),
        .i_valid (i_hdr_valid),
        .o_ready (o_hdr_ready),
        .o_data  (o_hdr_data),
        .o_valid (o_hdr_valid),
        .i_ready (i_hdr_ready)
    );

    // both fifos fill in segment order, so records and payload stay paired.
    stream_fifo #(
        .T     (logic [8:0]),
        .DEPTH (PAY_FIFO_DEPTH)
    ) u_pay_fifo (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_data  (pay_in),
        .i_valid (i_pay_valid),
        .o_ready (o_pay_ready),
        .o_data  (pay_out),
        .o_valid (o_m_valid),
        .i_ready (i_m_ready)
    );

    assign o_m_data = pay_out[7:0];
    assign o_m_last = pay_out[8];

endmodule

`default_nettype wire

/* verilog/tcp_rx_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tcp_rx_top (
    input  wire                  i_clk,
    input  wire                  i_rst,
    input  wire [15:0]           i_listen_port,

    input  wire [7:0]            i_s_data,
    input  wire                  i_s_last,
    input  wire                  i_s_valid,
    output logic                 o_s_ready,

    output tcp_rx_pkg::tcp_hdr_t o_hdr_data,
    output logic                 o_hdr_valid,
    input  wire                  i_hdr_ready,

    output logic [7:0]           o_m_data,
    output logic                 o_m_last,
    output logic                 o_m_valid,
    input  wire                  i_m_ready
);
    import tcp_rx_pkg::*;

    tcp_hdr_t   dec_hdr_data;
    logic       dec_hdr_valid;
    logic       dec_hdr_ready;
    logic [7:0] dec_pay_data;
    logic       dec_pay_last;
    logic       dec_pay_valid;
    logic       dec_pay_ready;

    tcp_hdr_t   flt_hdr_data;
    logic       flt_hdr_valid;
    logic       flt_hdr_ready;
    logic [7:0] flt_pay_data;
    logic       flt_pay_last;
    logic       flt_pay_valid;
    logic       flt_pay_ready;

    tcp_hdr_decoder u_decoder (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_s_data    (i_s_data),
        .i_s_last    (i_s_last),
        .i_s_valid   (i_s_valid),
        .o_s_ready   (o_s_ready),
        .o_hdr_data  (dec_hdr_data),
        .o_hdr_valid (dec_hdr_valid),
        .i_hdr_ready (dec_hdr_ready),
        .o_pay_data  (dec_pay_data),
        .o_pay_last  (dec_pay_last),
        .o_pay_valid (dec_pay_valid),
        .i_pay_ready (dec_pay_ready)
    );

    tcp_port_filter u_filter (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_listen_port (i_listen_port),
        .i_hdr_data    (dec_hdr_data),
        .i_hdr_valid   (dec_hdr_valid),
        .o_hdr_ready   (dec_hdr_ready),
        .i_pay_data    (dec_pay_data),
        .i_pay_last    (dec_pay_last),
        .i_pay_valid   (dec_pay_valid),
        .o_pay_ready   (dec_pay_ready),
        .o_hdr_data    (flt_hdr_data),
        .o_hdr_valid   (flt_hdr_valid),
        .i_hdr_ready   (flt_hdr_ready),
        .o_pay_data    (flt_pay_data),
        .o_pay_last    (flt_pay_last),
        .o_pay_valid   (flt_pay_valid),
        .i_pay_ready   (flt_pay_ready)
    );

    tcp_rx_result u_result (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_hdr_data  (flt_hdr_data),
        .i_hdr_valid (flt_hdr_valid),
        .o_hdr_ready (flt_hdr_ready),
        .i_pay_data  (flt_pay_data),
        .i_pay_last  (flt_pay_last),
        .i_pay_valid (flt_pay_valid),
        .o_pay_ready (flt_pay_ready),
        .o_hdr_data  (o_hdr_data),
        .o_hdr_valid (o_hdr_valid),
        .i_hdr_ready (i_hdr_ready),
        .o_m_data    (o_m_data),
        .o_m_last    (o_m_last),
        .o_m_valid   (o_m_valid),
        .i_m_ready   (i_m_ready)
    );

endmodule

`default_nettype wire
